/* rename_defines.svh */
// Rename front sizes
`ifndef RENAME_DEFINES_SVH
`define RENAME_DEFINES_SVH

// Architectural register count of RV32I
`define ARCH_REGS 32

// Physical registers, twice the architectural set
`define PHYS_REGS 64

// Decoded instruction queue entries
`define IQ_DEPTH 4

// ROB ids handed out round robin
`define ROB_DEPTH 8

`endif

/* rename_pkg.sv */
// Rename front types
`include "rename_defines.svh"

package rename_pkg;

    // Architectural register index
    typedef logic [$clog2(`ARCH_REGS)-1:0] arch_reg_t;

    // Physical register index
    typedef logic [$clog2(`PHYS_REGS)-1:0] phys_reg_t;

    // Tag of an instruction in the ROB
    typedef logic [$clog2(`ROB_DEPTH)-1:0] rob_id_t;

    // Decoded instruction as held in the queue
    typedef struct packed {
        logic [31:0] pc;
        arch_reg_t   rs1;
        arch_reg_t   rs2;
        arch_reg_t   rd;
        logic        use_rs1;
        logic        use_rs2;
        // Only set for a write to a nonzero rd
        logic        has_rd;
        logic        is_store;
    } inst_info_t;

endpackage : rename_pkg

/* rat_if.sv */
// Alias table lookup bus
`timescale 1ns/1ps

interface rat_if
    import rename_pkg::*;
();

    // Lookup and update requests from the dispatcher
    arch_reg_t rs1;
    arch_reg_t rs2;
    arch_reg_t rd;
    phys_reg_t new_prd;
    logic      write;

    // Current mappings, combinational from the table
    phys_reg_t prs1;
    phys_reg_t prs2;
    phys_reg_t old_prd;

    modport dispatch (
        output rs1, rs2, rd, new_prd, write,
        input  prs1, prs2, old_prd
    );

    // Alias table side
    modport tbl (
        input  rs1, rs2, rd, new_prd, write,
        output prs1, prs2, old_prd
    );

endinterface : rat_if

/* inst_decoder.sv */
// RV32I register field decoder
`timescale 1ns/1ps

module inst_decoder
    import rename_pkg::*;
(
    input  logic [31:0] word,
    input  logic [31:0] pc,
    output inst_info_t  info
);

    // Base opcodes of RV32I
    localparam logic [6:0] OPC_LUI    = 7'b0110111;
    localparam logic [6:0] OPC_AUIPC  = 7'b0010111;
    localparam logic [6:0] OPC_JAL    = 7'b1101111;
    localparam logic [6:0] OPC_JALR   = 7'b1100111;
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;
    localparam logic [6:0] OPC_LOAD   = 7'b0000011;
    localparam logic [6:0] OPC_STORE  = 7'b0100011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_OP     = 7'b0110011;

    logic [6:0] opcode;
    // Class writes a destination, before the x0 check
    logic       rd_write;

    assign opcode = word[6:0];

    always_comb begin
        info         = '0;
        info.pc      = pc;
        // Field positions are fixed across formats
        info.rs1     = word[19:15];
        info.rs2     = word[24:20];
        info.rd      = word[11:7];
        rd_write     = 1'b0;
        case (opcode)
            OPC_LUI, OPC_AUIPC, OPC_JAL: begin
                rd_write = 1'b1;
            end
            OPC_JALR, OPC_LOAD, OPC_OP_IMM: begin
                info.use_rs1 = 1'b1;
                rd_write     = 1'b1;
            end
            OPC_OP: begin
                info.use_rs1 = 1'b1;
                info.use_rs2 = 1'b1;
                rd_write     = 1'b1;
            end
            OPC_BRANCH: begin
                info.use_rs1 = 1'b1;
                info.use_rs2 = 1'b1;
            end
            OPC_STORE: begin
                info.use_rs1  = 1'b1;
                info.use_rs2  = 1'b1;
                info.is_store = 1'b1;
            end
            // Unknown opcode touches no registers
            default: ;
        endcase
        // Writes to x0 need no new mapping
        info.has_rd = rd_write && (word[11:7] != 5'd0);
    end

endmodule : inst_decoder

/* inst_queue.sv */
// Decoded instruction queue
`timescale 1ns/1ps
`include "rename_defines.svh"

module inst_queue
    import rename_pkg::*;
(
    input  logic       clk,
    input  logic       rst,
    input  logic       push,
    input  inst_info_t push_data,
    output logic       full,
    input  logic       pop,
    output logic       empty,
    output inst_info_t head
);

    localparam int PTR_W = $clog2(`IQ_DEPTH);
    localparam int CNT_W = $clog2(`IQ_DEPTH + 1);

    inst_info_t       entries [`IQ_DEPTH];
    logic [PTR_W-1:0] rd_ptr;
    logic [PTR_W-1:0] wr_ptr;
    logic [CNT_W-1:0] count;
    logic             push_ok;
    logic             pop_ok;

    assign full    = (count == CNT_W'(`IQ_DEPTH));
    assign empty   = (count == '0);
    // Push while full is dropped
    assign push_ok = push && !full;
    assign pop_ok  = pop && !empty;
    // Show-ahead head
    assign head    = entries[rd_ptr];

    always_ff @(posedge clk) begin
        if (push_ok) begin
            entries[wr_ptr] <= push_data;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            rd_ptr <= '0;
            wr_ptr <= '0;
            count  <= '0;
        end else begin
            if (push_ok) begin
                wr_ptr <= (wr_ptr == PTR_W'(`IQ_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (pop_ok) begin
                rd_ptr <= (rd_ptr == PTR_W'(`IQ_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            // Simultaneous push and pop keep the count
            if (push_ok && !pop_ok) begin
                count <= count + 1'b1;
            end else if (pop_ok && !push_ok) begin
                count <= count - 1'b1;
            end
        end
    end

endmodule : inst_queue

/* free_list.sv */
// Physical register free list
`timescale 1ns/1ps
`include "rename_defines.svh"

module free_list
    import rename_pkg::*;
(
    input  logic      clk,
    input  logic      rst,
    input  logic      push,
    input  phys_reg_t push_reg,
    input  logic      pop,
    output logic      empty,
    output phys_reg_t head
);

    // Registers beyond the architectural set start out free
    localparam int FL_DEPTH = `PHYS_REGS - `ARCH_REGS;
    localparam int PTR_W    = $clog2(FL_DEPTH);
    localparam int CNT_W    = $clog2(FL_DEPTH + 1);

    phys_reg_t        regs [FL_DEPTH];
    logic [PTR_W-1:0] rd_ptr;
    logic [PTR_W-1:0] wr_ptr;
    logic [CNT_W-1:0] count;
    logic             push_ok;
    logic             pop_ok;

    assign empty   = (count == '0);
    assign pop_ok  = pop && !empty;
    // A full list still takes a push when popped in the same cycle
    assign push_ok = push && ((count != CNT_W'(FL_DEPTH)) || pop_ok);
    assign head    = regs[rd_ptr];

    always_ff @(posedge clk) begin
        if (rst) begin
            // Fill with ARCH_REGS up to PHYS_REGS-1 in order
            for (int i = 0; i < FL_DEPTH; i++) begin
                regs[i] <= phys_reg_t'(`ARCH_REGS + i);
            end
            rd_ptr <= '0;
            wr_ptr <= '0;
            count  <= CNT_W'(FL_DEPTH);
        end else begin
            if (push_ok) begin
                regs[wr_ptr] <= push_reg;
                wr_ptr       <= (wr_ptr == PTR_W'(FL_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (pop_ok) begin
                rd_ptr <= (rd_ptr == PTR_W'(FL_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            if (push_ok && !pop_ok) begin
                count <= count + 1'b1;
            end else if (pop_ok && !push_ok) begin
                count <= count - 1'b1;
            end
        end
    end

endmodule : free_list

/* rat.sv */
// Register alias table
`timescale 1ns/1ps
`include "rename_defines.svh"

module rat
    import rename_pkg::*;
(
    input logic  clk,
    input logic  rst,
    rat_if.tbl   rat_bus
);

    // Current physical register of each architectural register
    phys_reg_t rename_map [`ARCH_REGS];

    always_ff @(posedge clk) begin
        if (rst) begin
            // Identity mapping out of reset
            for (int i = 0; i < `ARCH_REGS; i++) begin
                rename_map[i] <= phys_reg_t'(i);
            end
        end else if (rat_bus.write) begin
            rename_map[rat_bus.rd] <= rat_bus.new_prd;
        end
    end

    // Source lookups see the mapping before this cycle's update
    assign rat_bus.prs1    = rename_map[rat_bus.rs1];
    assign rat_bus.prs2    = rename_map[rat_bus.rs2];
    // Mapping being replaced, freed once the new one commits
    assign rat_bus.old_prd = rename_map[rat_bus.rd];

endmodule : rat

/* dispatcher.sv */
// Rename and dispatch control
`timescale 1ns/1ps
`include "rename_defines.svh"

module dispatcher
    import rename_pkg::*;
(
    input  logic        clk,
    input  logic        rst,
    // Instruction queue head
    input  logic        iq_empty,
    input  inst_info_t  iq_head,
    output logic        iq_pop,
    // Free list head
    input  logic        fl_empty,
    input  phys_reg_t   fl_head,
    output logic        fl_pop,
    rat_if.dispatch     rat_bus,
    // Back-pressure from the rest of the core
    input  logic        rs_full,
    input  logic        rob_full,
    input  logic        store_commit,
    // Renamed instruction
    output logic        dispatch_valid,
    output logic [31:0] dispatch_pc,
    output rob_id_t     dispatch_rob_id,
    output arch_reg_t   dispatch_rd,
    output phys_reg_t   dispatch_prd,
    output phys_reg_t   dispatch_old_prd,
    output phys_reg_t   dispatch_prs1,
    output phys_reg_t   dispatch_prs2,
    output logic        dispatch_use_rs1,
    output logic        dispatch_use_rs2,
    output logic        dispatch_has_rd,
    output logic        dispatch_is_store
);

    // Store in flight, holds dispatch until it commits
    logic    store_active;
    rob_id_t rob_id;

    // Head needs a free register only when it writes rd
    assign iq_pop = !iq_empty && !rs_full && !rob_full && !store_active
                    && (!fl_empty || !iq_head.has_rd);
    assign fl_pop = iq_pop && iq_head.has_rd;

    // Lookups come straight from the queue head
    assign rat_bus.rs1     = iq_head.rs1;
    assign rat_bus.rs2     = iq_head.rs2;
    assign rat_bus.rd      = iq_head.rd;
    assign rat_bus.new_prd = fl_head;
    assign rat_bus.write   = fl_pop;

    always_ff @(posedge clk) begin
        if (rst) begin
            store_active <= 1'b0;
        end else if (iq_pop && iq_head.is_store) begin
            store_active <= 1'b1;
        end else if (store_commit) begin
            store_active <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            rob_id         <= '0;
            dispatch_valid <= 1'b0;
        end else begin
            dispatch_valid <= iq_pop;
            if (iq_pop) begin
                rob_id <= (rob_id == rob_id_t'(`ROB_DEPTH - 1)) ? '0 : rob_id + 1'b1;
            end
        end
    end

    // Renamed fields, valid only with dispatch_valid
    always_ff @(posedge clk) begin
        if (iq_pop) begin
            dispatch_pc       <= iq_head.pc;
            dispatch_rob_id   <= rob_id;
            dispatch_rd       <= iq_head.rd;
            dispatch_prs1     <= rat_bus.prs1;
            dispatch_prs2     <= rat_bus.prs2;
            dispatch_use_rs1  <= iq_head.use_rs1;
            dispatch_use_rs2  <= iq_head.use_rs2;
            dispatch_has_rd   <= iq_head.has_rd;
            dispatch_is_store <= iq_head.is_store;
            // No destination means nothing allocated and nothing to free
            dispatch_prd      <= iq_head.has_rd ? fl_head : '0;
            dispatch_old_prd  <= iq_head.has_rd ? rat_bus.old_prd : '0;
        end
    end

endmodule : dispatcher

/* rename_top.sv */
// Rename and dispatch front
`timescale 1ns/1ps

module rename_top
    import rename_pkg::*;
(
    input  logic        clk,
    input  logic        rst,
    // Raw instruction input
    input  logic        in_valid,
    input  logic [31:0] in_word,
    input  logic [31:0] in_pc,
    output logic        in_ready,
    // Core status
    input  logic        rs_full,
    input  logic        rob_full,
    input  logic        store_commit,
    // Register returned at commit
    input  logic        free_valid,
    input  phys_reg_t   free_preg,
    // Renamed instruction
    output logic        dispatch_valid,
    output logic [31:0] dispatch_pc,
    output rob_id_t     dispatch_rob_id,
    output arch_reg_t   dispatch_rd,
    output phys_reg_t   dispatch_prd,
    output phys_reg_t   dispatch_old_prd,
    output phys_reg_t   dispatch_prs1,
    output phys_reg_t   dispatch_prs2,
    output logic        dispatch_use_rs1,
    output logic        dispatch_use_rs2,
    output logic        dispatch_has_rd,
    output logic        dispatch_is_store
);

    inst_info_t dec_info;
    inst_info_t iq_head;
    logic       iq_full;
    logic       iq_empty;
    logic       iq_pop;
    phys_reg_t  fl_head;
    logic       fl_empty;
    logic       fl_pop;

    rat_if rat_bus ();

    // Queue full is the only input back-pressure
    assign in_ready = !iq_full;

    inst_decoder inst_decoder_i (
        .word (in_word),
        .pc   (in_pc),
        .info (dec_info)
    );

    inst_queue inst_queue_i (
        .clk       (clk),
        .rst       (rst),
        .push      (in_valid),
        .push_data (dec_info),
        .full      (iq_full),
        .pop       (iq_pop),
        .empty     (iq_empty),
        .head      (iq_head)
    );

    free_list free_list_i (
        .clk      (clk),
        .rst      (rst),
        .push     (free_valid),
        .push_reg (free_preg),
        .pop      (fl_pop),
        .empty    (fl_empty),
        .head     (fl_head)
    );

    rat rat_i (
        .clk     (clk),
        .rst     (rst),
        .rat_bus (rat_bus.tbl)
    );

    dispatcher dispatcher_i (
        .clk               (clk),
        .rst               (rst),
        .iq_empty          (iq_empty),
        .iq_head           (iq_head),
        .iq_pop            (iq_pop),
        .fl_empty          (fl_empty),
        .fl_head           (fl_head),
        .fl_pop            (fl_pop),
        .rat_bus           (rat_bus.dispatch),
        .rs_full           (rs_full),
        .rob_full          (rob_full),
        .store_commit      (store_commit),
        .dispatch_valid    (dispatch_valid),
        .dispatch_pc       (dispatch_pc),
        .dispatch_rob_id   (dispatch_rob_id),
        .dispatch_rd       (dispatch_rd),
        .dispatch_prd      (dispatch_prd),
        .dispatch_old_prd  (dispatch_old_prd),
        .dispatch_prs1     (dispatch_prs1),
        .dispatch_prs2     (dispatch_prs2),
        .dispatch_use_rs1  (dispatch_use_rs1),
        .dispatch_use_rs2  (dispatch_use_rs2),
        .dispatch_has_rd   (dispatch_has_rd),
        .dispatch_is_store (dispatch_is_store)
    );

endmodule : rename_top

/* rename_props.sv */
// Dispatcher assertions
`timescale 1ns/1ps

module rename_props (
    input logic clk,
    input logic rst,
    input logic iq_pop,
    input logic fl_pop,
    input logic rs_full,
    input logic rob_full,
    input logic store_active,
    input logic dispatch_valid
);

    // A pop waits for every back-pressure source
    pop_blocked_a: assert property (@(posedge clk) disable iff (rst)
        iq_pop |-> !(rs_full || rob_full || store_active))
        else $error("Instruction queue popped while dispatch was blocked");

    // Destinations are only taken together with an instruction
    fl_with_iq_a: assert property (@(posedge clk) disable iff (rst)
        fl_pop |-> iq_pop)
        else $error("Free list popped without an instruction queue pop");

    // Registered output follows its pop by one cycle
    valid_after_pop_a: assert property (@(posedge clk) disable iff (rst)
        dispatch_valid |-> $past(iq_pop))
        else $error("dispatch_valid without a pop in the previous cycle");

endmodule : rename_props

bind dispatcher rename_props rename_props_i (
    .clk            (clk),
    .rst            (rst),
    .iq_pop         (iq_pop),
    .fl_pop         (fl_pop),
    .rs_full        (rs_full),
    .rob_full       (rob_full),
    .store_active   (store_active),
    .dispatch_valid (dispatch_valid)
);

/* tb_rename.sv */
// Rename front testbench
`timescale 1ns/1ps
`include "rename_defines.svh"

module tb_rename
    import rename_pkg::*;
();

    localparam int CLK_NS       = 8;
    localparam int RESET_CYCLES = 5;
    localparam int N_STREAM     = 150;
    localparam int N_ROB        = 20;
    localparam int N_BUSY       = 150;
    localparam int N_STORE      = 40;
    localparam int N_FREE       = 40 + `IQ_DEPTH;
    localparam int N_TOTAL      = 1 + N_STREAM + N_ROB + N_BUSY + N_STORE + N_FREE;
    // Worst case cycles one instruction may need under stalls
    localparam int STALL_BOUND  = 40;
    localparam int WATCHDOG_NS  = (N_TOTAL * STALL_BOUND + 6 * 20) * CLK_NS;

    // Instruction classes
    localparam int C_LUI     = 0;
    localparam int C_AUIPC   = 1;
    localparam int C_JAL     = 2;
    localparam int C_JALR    = 3;
    localparam int C_BRANCH  = 4;
    localparam int C_LOAD    = 5;
    localparam int C_STORE   = 6;
    localparam int C_OP_IMM  = 7;
    localparam int C_OP      = 8;
    localparam int C_UNKNOWN = 9;

    logic        clk;
    logic        rst;
    logic        in_valid;
    logic [31:0] in_word;
    logic [31:0] in_pc;
    logic        in_ready;
    logic        rs_full;
    logic        rob_full;
    logic        store_commit;
    logic        free_valid;
    phys_reg_t   free_preg;
    logic        dispatch_valid;
    logic [31:0] dispatch_pc;
    rob_id_t     dispatch_rob_id;
    arch_reg_t   dispatch_rd;
    phys_reg_t   dispatch_prd;
    phys_reg_t   dispatch_old_prd;
    phys_reg_t   dispatch_prs1;
    phys_reg_t   dispatch_prs2;
    logic        dispatch_use_rs1;
    logic        dispatch_use_rs2;
    logic        dispatch_has_rd;
    logic        dispatch_is_store;

    // Reference model state
    inst_info_t  exp_q [$];
    phys_reg_t   model_map [`ARCH_REGS];
    phys_reg_t   model_free [$];
    // Old mappings of checked dispatches, ready to return
    phys_reg_t   retire_q [$];
    rob_id_t     model_rob;

    logic [31:0] lfsr_state = 32'd65888;
    logic [31:0] next_pc;
    logic        busy_mode;
    logic        frees_on;
    logic        store_block;
    logic        commit_pending;
    logic        prev_busy;
    phys_reg_t   last_prs1;
    phys_reg_t   last_prs2;
    int          errors;
    int          sent_count;
    int          disp_count;
    int          rd_disp_count;
    int          tests_run;

    rename_top rename_top_i (
        .clk               (clk),
        .rst               (rst),
        .in_valid          (in_valid),
        .in_word           (in_word),
        .in_pc             (in_pc),
        .in_ready          (in_ready),
        .rs_full           (rs_full),
        .rob_full          (rob_full),
        .store_commit      (store_commit),
        .free_valid        (free_valid),
        .free_preg         (free_preg),
        .dispatch_valid    (dispatch_valid),
        .dispatch_pc       (dispatch_pc),
        .dispatch_rob_id   (dispatch_rob_id),
        .dispatch_rd       (dispatch_rd),
        .dispatch_prd      (dispatch_prd),
        .dispatch_old_prd  (dispatch_old_prd),
        .dispatch_prs1     (dispatch_prs1),
        .dispatch_prs2     (dispatch_prs2),
        .dispatch_use_rs1  (dispatch_use_rs1),
        .dispatch_use_rs2  (dispatch_use_rs2),
        .dispatch_has_rd   (dispatch_has_rd),
        .dispatch_is_store (dispatch_is_store)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_NS / 2) clk = ~clk;
    end

    // Galois LFSR, x^32 + x^22 + x^2 + x + 1
    function automatic logic lfsr_step();
        logic out_bit;
        out_bit    = lfsr_state[0];
        lfsr_state = lfsr_state >> 1;
        if (out_bit) begin
            lfsr_state = lfsr_state ^ 32'h8020_0003;
        end
        return out_bit;
    endfunction

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] val;
        val = '0;
        for (int i = 0; i < n; i++) begin
            val = {val[30:0], lfsr_step()};
        end
        return val;
    endfunction

    function automatic logic [6:0] opcode_of(input int cls);
        case (cls)
            C_LUI:    return 7'b0110111;
            C_AUIPC:  return 7'b0010111;
            C_JAL:    return 7'b1101111;
            C_JALR:   return 7'b1100111;
            C_BRANCH: return 7'b1100011;
            C_LOAD:   return 7'b0000011;
            C_STORE:  return 7'b0100011;
            C_OP_IMM: return 7'b0010011;
            C_OP:     return 7'b0110011;
            // FENCE, outside the decoded set
            default:  return 7'b0001111;
        endcase
    endfunction

    // Register usage per RV32I instruction class
    function automatic inst_info_t expected_info(input int cls, input logic [4:0] rd,
                                                 input logic [4:0] rs1, input logic [4:0] rs2,
                                                 input logic [31:0] pc);
        inst_info_t info;
        logic       writes;
        info          = '0;
        info.pc       = pc;
        info.rs1      = rs1;
        info.rs2      = rs2;
        info.rd       = rd;
        writes        = cls inside {C_LUI, C_AUIPC, C_JAL, C_JALR, C_LOAD, C_OP_IMM, C_OP};
        info.use_rs1  = cls inside {C_JALR, C_BRANCH, C_LOAD, C_STORE, C_OP_IMM, C_OP};
        info.use_rs2  = cls inside {C_BRANCH, C_STORE, C_OP};
        info.is_store = (cls == C_STORE);
        // x0 is never renamed
        info.has_rd   = writes && (rd != 5'd0);
        return info;
    endfunction

    task automatic compare(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            errors++;
            $display("FAIL %s got 0x%0h expected 0x%0h", name, got, exp);
        end
    endtask

    task automatic note_error(input string msg);
        errors++;
        $display("%s", msg);
    endtask

    task automatic apply_reset();
        @(posedge clk);
        rst      <= 1'b1;
        in_valid <= 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        rst <= 1'b0;
        // Model starts from identity map and registers 32 to 63 free
        for (int i = 0; i < `ARCH_REGS; i++) begin
            model_map[i] = phys_reg_t'(i);
        end
        model_free.delete();
        for (int i = `ARCH_REGS; i < `PHYS_REGS; i++) begin
            model_free.push_back(phys_reg_t'(i));
        end
        exp_q.delete();
        retire_q.delete();
        model_rob      = '0;
        store_block    = 1'b0;
        commit_pending = 1'b0;
        sent_count     = 0;
        disp_count     = 0;
        rd_disp_count  = 0;
    endtask

    // Pushes one word once the queue has room
    task automatic send_inst(input int cls, input logic [4:0] rd,
                             input logic [4:0] rs1, input logic [4:0] rs2);
        logic [9:0] filler;
        @(negedge clk);
        filler = 10'(rand_bits(10));
        while (!in_ready) @(negedge clk);
        @(posedge clk);
        in_valid <= 1'b1;
        in_word  <= {filler[6:0], rs2, rs1, filler[9:7], rd, opcode_of(cls)};
        in_pc    <= next_pc;
        exp_q.push_back(expected_info(cls, rd, rs1, rs2, next_pc));
        next_pc = next_pc + 32'd4;
        sent_count++;
        @(posedge clk);
        in_valid <= 1'b0;
    endtask

    task automatic send_class(input int cls, input logic force_rd);
        logic [4:0] rd;
        logic [4:0] rs1;
        logic [4:0] rs2;
        @(negedge clk);
        rd  = 5'(rand_bits(5));
        rs1 = 5'(rand_bits(5));
        rs2 = 5'(rand_bits(5));
        if (force_rd && rd == 5'd0) begin
            rd = 5'd1;
        end
        send_inst(cls, rd, rs1, rs2);
    endtask

    // Any class, unknown opcode included
    task automatic send_random();
        int cls;
        @(negedge clk);
        cls = int'(rand_bits(4) % 32'(C_UNKNOWN + 1));
        send_class(cls, 1'b0);
    endtask

    // Waits for the model to drain, then reports the test
    task automatic finish_test(input string name, input int base_errors);
        while (exp_q.size() != 0 || store_block) @(negedge clk);
        repeat (4) @(negedge clk);
        compare("dispatch_count", disp_count, sent_count);
        // Drained queue takes words again
        compare("in_ready", 32'(in_ready), 32'd1);
        busy_mode = 1'b0;
        tests_run++;
        $display("%s: %0d dispatched, %0d errors", name, disp_count, errors - base_errors);
    endtask

    task automatic check_dispatch();
        inst_info_t e;
        phys_reg_t  new_prd;
        disp_count++;
        if (exp_q.size() == 0) begin
            note_error("Dispatch appeared with no instruction outstanding");
            return;
        end
        e = exp_q.pop_front();
        compare("dispatch_pc", dispatch_pc, e.pc);
        compare("dispatch_rob_id", 32'(dispatch_rob_id), 32'(model_rob));
        compare("dispatch_has_rd", 32'(dispatch_has_rd), 32'(e.has_rd));
        compare("dispatch_is_store", 32'(dispatch_is_store), 32'(e.is_store));
        compare("dispatch_use_rs1", 32'(dispatch_use_rs1), 32'(e.use_rs1));
        compare("dispatch_use_rs2", 32'(dispatch_use_rs2), 32'(e.use_rs2));
        // Sources see the map before this instruction's own update
        if (e.use_rs1) begin
            compare("dispatch_prs1", 32'(dispatch_prs1), 32'(model_map[e.rs1]));
        end
        if (e.use_rs2) begin
            compare("dispatch_prs2", 32'(dispatch_prs2), 32'(model_map[e.rs2]));
        end
        last_prs1 = dispatch_prs1;
        last_prs2 = dispatch_prs2;
        model_rob = rob_id_t'((int'(model_rob) + 1) % `ROB_DEPTH);
        if (e.has_rd) begin
            if (model_free.size() == 0) begin
                note_error("Destination handed out while no register was free");
                return;
            end
            new_prd = model_free.pop_front();
            compare("dispatch_rd", 32'(dispatch_rd), 32'(e.rd));
            compare("dispatch_prd", 32'(dispatch_prd), 32'(new_prd));
            compare("dispatch_old_prd", 32'(dispatch_old_prd), 32'(model_map[e.rd]));
            retire_q.push_back(model_map[e.rd]);
            model_map[e.rd] = new_prd;
            rd_disp_count++;
        end
    endtask

    // Core status driver, rising edges only
    initial begin : drive_status
        phys_reg_t ret;
        rs_full      = 1'b0;
        rob_full     = 1'b0;
        store_commit = 1'b0;
        free_valid   = 1'b0;
        free_preg    = '0;
        forever begin
            @(posedge clk);
            if (rst) begin
                rs_full      <= 1'b0;
                rob_full     <= 1'b0;
                store_commit <= 1'b0;
                free_valid   <= 1'b0;
            end else begin
                if (busy_mode) begin
                    rs_full  <= (rand_bits(2) == 32'd0);
                    rob_full <= (rand_bits(2) == 32'd0);
                end else begin
                    rs_full  <= 1'b0;
                    rob_full <= 1'b0;
                end
                // One commit pulse per dispatched store
                if (store_block && !commit_pending && !store_commit) begin
                    store_commit <= (rand_bits(1) == 32'd1);
                end else begin
                    store_commit <= 1'b0;
                end
                if (frees_on && retire_q.size() > 0 && rand_bits(1) == 32'd1) begin
                    ret = retire_q.pop_front();
                    free_valid <= 1'b1;
                    free_preg  <= ret;
                    model_free.push_back(ret);
                end else begin
                    free_valid <= 1'b0;
                end
            end
        end
    end

    // Output monitor, sampled mid-cycle
    initial begin : monitor
        prev_busy = 1'b0;
        forever begin
            @(negedge clk);
            if (rst) begin
                prev_busy = 1'b0;
            end else begin
                if (dispatch_valid && prev_busy) begin
                    note_error("Dispatch followed a cycle with rs_full or rob_full high");
                end
                if (dispatch_valid && store_block) begin
                    note_error("Dispatch while a store was still waiting for commit");
                end
                // Commit in cycle C allows a pop in C+1
                if (commit_pending) begin
                    store_block    = 1'b0;
                    commit_pending = 1'b0;
                end else if (store_commit && store_block) begin
                    commit_pending = 1'b1;
                end
                if (dispatch_valid && dispatch_is_store) begin
                    store_block = 1'b1;
                end
                if (dispatch_valid) begin
                    check_dispatch();
                end
                prev_busy = rs_full || rob_full;
            end
        end
    end

    initial begin : watchdog
        #(WATCHDOG_NS);
        $display("Timeout: dispatch stalled longer than the whole run should take");
        $display("Test failed");
        $finish;
    end

    initial begin : main
        int base;
        rst       = 1'b1;
        in_valid  = 1'b0;
        in_word   = '0;
        in_pc     = '0;
        errors    = 0;
        tests_run = 0;
        busy_mode = 1'b0;
        frees_on  = 1'b1;
        next_pc   = 32'h0000_1000;

        // Reset state and identity sources
        base = errors;
        apply_reset();
        repeat (3) begin
            @(negedge clk);
            compare("dispatch_valid", 32'(dispatch_valid), 32'd0);
        end
        send_inst(C_OP, 5'd3, 5'd5, 5'd9);
        while (exp_q.size() != 0) @(negedge clk);
        compare("dispatch_prs1", 32'(last_prs1), 32'd5);
        compare("dispatch_prs2", 32'(last_prs2), 32'd9);
        finish_test("reset_state", base);

        // Random stream with stores and returns
        base = errors;
        apply_reset();
        for (int i = 0; i < N_STREAM; i++) begin
            send_random();
        end
        finish_test("random_stream", base);

        // ROB ids wrap modulo 8
        base = errors;
        apply_reset();
        for (int i = 0; i < N_ROB; i++) begin
            send_class(C_OP, 1'b0);
        end
        finish_test("rob_id_wrap", base);

        // rs_full and rob_full toggled at random
        base = errors;
        apply_reset();
        busy_mode = 1'b1;
        for (int i = 0; i < N_BUSY; i++) begin
            send_random();
        end
        finish_test("back_pressure", base);

        // Store heavy mix
        base = errors;
        apply_reset();
        for (int i = 0; i < N_STORE; i++) begin
            @(negedge clk);
            case (rand_bits(2) % 32'd3)
                32'd0:   send_class(C_STORE, 1'b0);
                32'd1:   send_class(C_OP, 1'b0);
                default: send_class(C_BRANCH, 1'b0);
            endcase
        end
        finish_test("store_stall", base);

        // Free list runs dry with frees withheld
        base = errors;
        apply_reset();
        frees_on = 1'b0;
        for (int i = 0; i < 32; i++) begin
            send_class(C_OP, 1'b1);
            if (i % 4 == 3) begin
                send_class(C_BRANCH, 1'b0);
            end
        end
        // Stuck writer with branches filling the queue behind it
        send_class(C_OP, 1'b1);
        repeat (`IQ_DEPTH - 1) begin
            send_class(C_BRANCH, 1'b0);
        end
        while (disp_count < 40) @(negedge clk);
        repeat (10) @(negedge clk);
        compare("rd_dispatch_count", rd_disp_count, 32'd32);
        compare("pending_count", 32'(exp_q.size()), 32'(`IQ_DEPTH));
        // Full queue holds off new words
        compare("in_ready", 32'(in_ready), 32'd0);
        frees_on = 1'b1;
        finish_test("free_exhaust", base);

        $display("Summary: %0d tests, %0d errors", tests_run, errors);
        if (errors == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule : tb_rename

/* list.f */
+incdir+.
rename_pkg.sv
rat_if.sv
inst_decoder.sv
inst_queue.sv
free_list.sv
rat.sv
dispatcher.sv
rename_top.sv
rename_props.sv
tb_rename.sv

/* run.sh */
#!/bin/sh
# Build and run the rename front testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -f list.f --top-module tb_rename \
    -Mdir obj_dir -o tb_rename_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/tb_rename_sim > "$LOG" 2>&1
sim_status=$?
cat "$LOG"
if [ $sim_status -ne 0 ]; then
    echo "Simulation exited with status $sim_status"
    exit 1
fi

if grep -q "Test failed" "$LOG"; then
    exit 1
fi
exit 0
